//--- all.f
+incdir+.
la32_isa_pkg.sv
core_pkg.sv
inst_decode.sv
regfile.sv
alu.sv
mycpu_top.sv
mycpu_chk.sv
tb_mycpu.sv

//--- alu.sv
`timescale 1ns/1ns

module alu import la32_isa_pkg::*; import core_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);
    logic        use_sub;
    word_t       adder_b;
    logic [32:0] adder_sum;
    word_t       slt_result;
    word_t       sltu_result;
    word_t       sll_result;
    word_t       srl_result;
    word_t       sra_result;
    logic [4:0]  shamt;

    // sub, slt and sltu all take src1 + ~src2 + 1.
    assign use_sub   = alu_op[1] | alu_op[2] | alu_op[3];
    assign adder_b   = use_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, use_sub};

    // signed less-than from the operand signs and the difference sign.
    assign slt_result = {31'd0, (alu_src1[31] & ~alu_src2[31])
                              | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31])};

    // no carry out of the subtraction means src1 < src2 unsigned.
    assign sltu_result = {31'd0, ~adder_sum[32]};

    assign shamt      = alu_src2[4:0];
    assign sll_result = alu_src1 << shamt;
    assign srl_result = alu_src1 >> shamt;
    assign sra_result = word_t'($signed(alu_src1) >>> shamt);

    assign alu_result = ({32{alu_op[0] | alu_op[1]}} & adder_sum[31:0])
                      | ({32{alu_op[2]}}  & slt_result)
                      | ({32{alu_op[3]}}  & sltu_result)
                      | ({32{alu_op[4]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[5]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[6]}}  & (alu_src1 | alu_src2))
                      | ({32{alu_op[7]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[8]}}  & sll_result)
                      | ({32{alu_op[9]}}  & srl_result)
                      | ({32{alu_op[10]}} & sra_result)
                      | ({32{alu_op[11]}} & alu_src2);

endmodule

//--- core_pkg.sv
package core_pkg;

    // data word held in registers and memory.
    typedef logic [31:0] word_t;

    // byte address.
    typedef logic [31:0] addr_t;

    // steps of the multi-cycle sequence.
    typedef enum logic [2:0] {
        step_if,
        step_id,
        step_exe,
        step_mem,
        step_wb
    } step_t;

endpackage

//--- cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// pc of the first instruction fetched after reset.
`define CPU_PC_RESET 32'h1c00_0000

// number of general registers including r0.
`define CPU_NUM_REGS 32

// instruction memory depth in 32-bit words.
`define CPU_IMEM_WORDS 256

// data memory depth in 32-bit words.
`define CPU_DMEM_WORDS 256

`endif

//--- inst_decode.sv
`timescale 1ns/1ns

module inst_decode import la32_isa_pkg::*; (
    input  inst_t       inst,
    output alu_op_t     alu_op,
    output inst_class_t inst_class,
    output reg_num_t    rj,
    output reg_num_t    rk_or_rd,
    output reg_num_t    dest,
    output imm_t        imm,
    output imm_t        br_offs,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        reg_write,
    output logic        is_beq,
    output logic        is_bne,
    output logic        is_jirl
);
    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_num_t    rd;
    reg_num_t    rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_2ri5;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w;
    logic        inst_ld_w, inst_st_w;
    logic        inst_b, inst_bl;
    logic        need_si20;
    logic        need_si26;
    logic        src2_is_4;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    // three-register and shift-by-immediate groups share the upper fields.
    assign is_3r   = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_2ri5 = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_2ri5 && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_2ri5 && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_2ri5 && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign is_jirl      = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign is_beq       = (op_31_26 == 6'h16);
    assign is_bne       = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    // link instructions compute pc+4 on the adder.
    assign alu_op[0]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | is_jirl | inst_bl;
    assign alu_op[1]  = inst_sub_w;
    assign alu_op[2]  = inst_slt;
    assign alu_op[3]  = inst_sltu;
    assign alu_op[4]  = inst_and;
    assign alu_op[5]  = inst_nor;
    assign alu_op[6]  = inst_or;
    assign alu_op[7]  = inst_xor;
    assign alu_op[8]  = inst_slli_w;
    assign alu_op[9]  = inst_srli_w;
    assign alu_op[10] = inst_srai_w;
    assign alu_op[11] = inst_lu12i_w;

    always_comb begin
        if (inst_ld_w)
            inst_class = class_load;
        else if (inst_st_w)
            inst_class = class_store;
        else if (is_beq || is_bne || inst_b)
            inst_class = class_branch;
        else if (is_jirl || inst_bl)
            inst_class = class_jump_link;
        else if (|alu_op)
            inst_class = class_alu;
        else
            inst_class = class_nop;
    end

    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = is_jirl | inst_bl;

    // ui5 sits in the low bits of the si12 field, so one extension serves both.
    assign imm = src2_is_4 ? 32'h4 :
                 need_si20 ? {i20, 12'b0} :
                             {{20{i12[11]}}, i12};

    assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b00} :
                                 {{14{i16[15]}}, i16, 2'b00};

    assign rk_or_rd    = (is_beq || is_bne || inst_st_w) ? rd : rk;
    assign dest        = inst_bl ? 5'd1 : rd;
    assign src1_is_pc  = is_jirl | inst_bl;
    assign src2_is_imm = is_2ri5 | inst_addi_w | inst_ld_w | inst_st_w
                       | inst_lu12i_w | src2_is_4;
    assign reg_write   = (inst_class == class_alu) || (inst_class == class_load)
                       || (inst_class == class_jump_link);

endmodule

//--- la32_isa_pkg.sv
package la32_isa_pkg;

    // one raw instruction word.
    typedef logic [31:0] inst_t;

    // general register number.
    typedef logic [4:0] reg_num_t;

    // immediate after extension and shifting.
    typedef logic [31:0] imm_t;

    // one-hot alu function select.
    // bit 0 add, 1 sub, 2 slt, 3 sltu, 4 and, 5 nor,
    // 6 or, 7 xor, 8 sll, 9 srl, 10 sra, 11 lui.
    typedef logic [11:0] alu_op_t;

    // coarse instruction kind that drives the step sequence.
    typedef enum logic [2:0] {
        class_alu,
        class_load,
        class_store,
        class_branch,
        class_jump_link,
        class_nop
    } inst_class_t;

endpackage

//--- mycpu_chk.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mycpu_chk import core_pkg::*; (
    input logic       clk,
    input logic       reset,
    input addr_t      inst_sram_addr,
    input logic       data_sram_we,
    input addr_t      data_sram_addr,
    input addr_t      debug_wb_pc,
    input logic [3:0] debug_wb_rf_we
);
    logic [2:0] since_wb;
    logic       fired;

    initial fired = 1'b0;

    // saturating count of cycles since the last trace pulse.
    always_ff @(posedge clk) begin
        if (reset)
            since_wb <= 3'd7;
        else if (debug_wb_rf_we != 4'h0)
            since_wb <= 3'd0;
        else if (since_wb != 3'd7)
            since_wb <= since_wb + 3'd1;
    end

    store_single: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
        else begin
            fired = 1'b1;
            $error("data_sram_we high in two consecutive cycles");
        end

    trace_we_whole: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we == 4'h0) || (debug_wb_rf_we == 4'hf))
        else begin
            fired = 1'b1;
            $error("debug_wb_rf_we partly set");
        end

    trace_after_reset: assert property (@(posedge clk)
        reset |=> (debug_wb_rf_we == 4'h0))
        else begin
            fired = 1'b1;
            $error("trace pulse right after reset");
        end

    // four cycles apart means three idle cycles in between.
    trace_spacing: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we != 4'h0) |-> (since_wb >= 3'd3))
        else begin
            fired = 1'b1;
            $error("trace pulses closer than four cycles");
        end

    store_timing: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> ($past(inst_sram_addr, 3) == debug_wb_pc))
        else begin
            fired = 1'b1;
            $error("store not three cycles after its fetch");
        end

    store_range: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> ((data_sram_addr[1:0] == 2'b00)
                          && (data_sram_addr[31:2] < `CPU_DMEM_WORDS)))
        else begin
            fired = 1'b1;
            $error("store address outside data memory");
        end

endmodule

//--- mycpu_top.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mycpu_top import la32_isa_pkg::*; import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // instruction sram
    output addr_t      inst_sram_addr,
    input  inst_t      inst_sram_rdata,
    // data sram
    output logic       data_sram_we,
    output addr_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,
    // writeback trace
    output addr_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_num_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    step_t       state;
    step_t       state_next;
    addr_t       pc;
    addr_t       inst_pc_q;
    addr_t       seq_pc;
    addr_t       br_target;
    addr_t       next_pc;
    inst_t       inst_q;
    inst_t       cur_inst;
    word_t       rj_q;
    word_t       rkd_q;
    imm_t        imm_q;
    word_t       alu_result_q;

    alu_op_t     alu_op;
    inst_class_t inst_class;
    reg_num_t    rj;
    reg_num_t    rk_or_rd;
    reg_num_t    dest;
    imm_t        imm;
    imm_t        br_offs;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        reg_write;
    logic        is_beq;
    logic        is_bne;
    logic        is_jirl;

    word_t       rj_value;
    word_t       rkd_value;
    word_t       alu_src1;
    word_t       alu_src2;
    word_t       alu_result;
    word_t       final_result;
    logic        rj_eq_rd;
    logic        br_taken;
    logic        rf_we;

    // the fetched word is only on the sram bus during decode.
    assign cur_inst = (state == step_id) ? inst_sram_rdata : inst_q;

    inst_decode u_decode (
        .inst        (cur_inst),
        .alu_op      (alu_op),
        .inst_class  (inst_class),
        .rj          (rj),
        .rk_or_rd    (rk_or_rd),
        .dest        (dest),
        .imm         (imm),
        .br_offs     (br_offs),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .reg_write   (reg_write),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_jirl     (is_jirl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rj_value),
        .raddr2 (rk_or_rd),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (final_result)
    );

    always_comb begin
        case (state)
            step_if:  state_next = step_id;
            step_id:  state_next = (inst_class == class_branch) ? step_if : step_exe;
            step_exe: begin
                if ((inst_class == class_load) || (inst_class == class_store))
                    state_next = step_mem;
                else
                    state_next = step_wb;
            end
            step_mem: state_next = (inst_class == class_load) ? step_wb : step_if;
            step_wb:  state_next = step_if;
            default:  state_next = step_if;
        endcase
    end

    // branch resolution uses the register values read during decode.
    assign rj_eq_rd  = (rj_value == rkd_value);
    assign br_taken  = (is_beq && rj_eq_rd)
                     || (is_bne && !rj_eq_rd)
                     || ((inst_class == class_branch) && !is_beq && !is_bne)
                     || (inst_class == class_jump_link);
    assign br_target = is_jirl ? (rj_value + br_offs) : (pc + br_offs);
    assign seq_pc    = pc + 32'd4;
    assign next_pc   = br_taken ? br_target : seq_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= step_if;
            pc    <= `CPU_PC_RESET;
        end else begin
            state <= state_next;
            if (state == step_id) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == step_id) begin
            inst_q    <= inst_sram_rdata;
            inst_pc_q <= pc;
            rj_q      <= rj_value;
            rkd_q     <= rkd_value;
            imm_q     <= imm;
        end
        if (state == step_exe) begin
            alu_result_q <= alu_result;
        end
    end

    // link instructions add 4 to their own pc.
    assign alu_src1 = src1_is_pc ? inst_pc_q : rj_q;
    assign alu_src2 = src2_is_imm ? imm_q : rkd_q;

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    assign inst_sram_addr = pc;

    // stores write the rd value at the alu address for one cycle.
    assign data_sram_we    = (state == step_mem) && (inst_class == class_store);
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = rkd_q;

    assign final_result = (inst_class == class_load) ? data_sram_rdata : alu_result_q;
    assign rf_we        = (state == step_wb) && reg_write;

    assign debug_wb_pc       = inst_pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

//--- regfile.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module regfile import la32_isa_pkg::*; import core_pkg::*; (
    input  logic     clk,
    input  reg_num_t raddr1,
    output word_t    rdata1,
    input  reg_num_t raddr2,
    output word_t    rdata2,
    input  logic     we,
    input  reg_num_t waddr,
    input  word_t    wdata
);
    word_t regs [`CPU_NUM_REGS];

    // r0 is hardwired, so writes to it are dropped.
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module tb_mycpu \
    --Mdir obj_dir -o tb_mycpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_mycpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi
if echo "$out" | grep -q "^NO ERRORS$"; then
    exit 0
fi
exit 1

//--- tb_mycpu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_mycpu import la32_isa_pkg::*; import core_pkg::*; ();
    logic       clk;
    logic       reset;
    addr_t      inst_sram_addr;
    inst_t      inst_sram_rdata;
    logic       data_sram_we;
    addr_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    addr_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_num_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    inst_t      imem [`CPU_IMEM_WORDS];
    word_t      dmem [`CPU_DMEM_WORDS];
    word_t      m_regs [`CPU_NUM_REGS];
    word_t      m_dmem [`CPU_DMEM_WORDS];
    addr_t      m_pc;
    addr_t      inst_addr_q;
    addr_t      data_addr_q;
    addr_t      halt_pc;
    int         cycle_count;
    int         halt_count;
    int         prog_len;
    int         ev_kind;
    addr_t      ev_pc;
    reg_num_t   ev_num;
    word_t      ev_val;
    addr_t      ev_addr;

    localparam inst_t halt_word = 32'h5000_0000;
    localparam int    cycle_limit = 1200;

    mycpu_top DUT (.*);

    bind mycpu_top mycpu_chk u_chk (
        .clk            (clk),
        .reset          (reset),
        .inst_sram_addr (inst_sram_addr),
        .data_sram_we   (data_sram_we),
        .data_sram_addr (data_sram_addr),
        .debug_wb_pc    (debug_wb_pc),
        .debug_wb_rf_we (debug_wb_rf_we)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic inst_t enc_3r(logic [4:0] f, reg_num_t rd, reg_num_t rj, reg_num_t rk);
        return {12'h001, f, rk, rj, rd};
    endfunction

    function automatic inst_t enc_shift(logic [4:0] f, reg_num_t rd, reg_num_t rj,
                                        logic [4:0] ui5);
        return {12'h004, f, ui5, rj, rd};
    endfunction

    function automatic inst_t enc_ri12(logic [9:0] op, reg_num_t rd, reg_num_t rj,
                                       logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic inst_t enc_ri16(logic [5:0] op, reg_num_t rd, reg_num_t rj,
                                       logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic inst_t enc_i26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [7:0] imem_index(addr_t a);
        logic [31:0] off;
        off = (a - `CPU_PC_RESET) >> 2;
        return off[7:0];
    endfunction

    task automatic put(inst_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_event(int got_kind, int exp_kind);
        assert (got_kind == exp_kind) else begin
            $display("DUT event of kind %0d does not match reference event of kind %0d",
                     got_kind, exp_kind);
            stop_on_error();
        end
    endtask

    // runs the reference until the next register write (1) or store (2).
    task automatic model_next(output int kind, output addr_t e_pc, output reg_num_t e_num,
                              output word_t e_val, output addr_t e_addr);
        inst_t       w;
        word_t       a;
        word_t       b;
        word_t       d;
        word_t       si12;
        word_t       o16;
        word_t       o26;
        word_t       res;
        addr_t       npc;
        logic [31:0] ea;
        int          n;
        kind = 0;
        e_pc = 32'd0;
        e_num = 5'd0;
        e_val = 32'd0;
        e_addr = 32'd0;
        n = 0;
        while ((kind == 0) && (n < 100)) begin
            w = imem[imem_index(m_pc)];
            if (w == halt_word)
                break;
            a = m_regs[w[9:5]];
            b = m_regs[w[14:10]];
            d = m_regs[w[4:0]];
            si12 = {{20{w[21]}}, w[21:10]};
            o16 = {{14{w[25]}}, w[25:10], 2'b00};
            o26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            res = 32'd0;
            npc = m_pc + 32'd4;
            e_num = w[4:0];
            ea = a + si12;
            if (w[31:20] == 12'h001) begin
                kind = 1;
                case (w[19:15])
                    5'h00: res = a + b;
                    5'h02: res = a - b;
                    5'h04: res = {31'd0, $signed(a) < $signed(b)};
                    5'h05: res = {31'd0, a < b};
                    5'h08: res = ~(a | b);
                    5'h09: res = a & b;
                    5'h0a: res = a | b;
                    5'h0b: res = a ^ b;
                    default: kind = 0;
                endcase
            end else if (w[31:20] == 12'h004) begin
                kind = 1;
                case (w[19:15])
                    5'h01: res = a << w[14:10];
                    5'h09: res = a >> w[14:10];
                    5'h11: res = $signed(a) >>> w[14:10];
                    default: kind = 0;
                endcase
            end else if (w[31:22] == 10'h00a) begin
                kind = 1;
                res = ea;
            end else if (w[31:25] == 7'h0a) begin
                kind = 1;
                res = {w[24:5], 12'h000};
            end else if (w[31:22] == 10'h0a2) begin
                kind = 1;
                res = m_dmem[ea[9:2]];
            end else if (w[31:22] == 10'h0a6) begin
                kind = 2;
                e_addr = ea;
                e_val = d;
                m_dmem[ea[9:2]] = d;
            end else if (w[31:26] == 6'h13) begin
                kind = 1;
                res = m_pc + 32'd4;
                npc = a + o16;
            end else if (w[31:26] == 6'h14) begin
                npc = m_pc + o26;
            end else if (w[31:26] == 6'h15) begin
                kind = 1;
                res = m_pc + 32'd4;
                e_num = 5'd1;
                npc = m_pc + o26;
            end else if ((w[31:26] == 6'h16) && (a == d)) begin
                npc = m_pc + o16;
            end else if ((w[31:26] == 6'h17) && (a != d)) begin
                npc = m_pc + o16;
            end
            if (kind == 1) begin
                e_val = res;
                if (e_num != 5'd0)
                    m_regs[e_num] = res;
            end
            e_pc = m_pc;
            m_pc = npc;
            n++;
        end
    endtask

    // test program with every opcode, an r0 write, an undefined word, a loop and a call.
    task automatic build_program();
        word_t r1;
        word_t r2;
        word_t r3;
        word_t r4;
        r1 = $urandom;
        r2 = $urandom;
        r3 = $urandom;
        r4 = $urandom;
        prog_len = 0;
        put({6'h05, 1'b0, r1[19:0], 5'd4});
        put(enc_ri12(10'h00a, 5'd4, 5'd4, r2[11:0]));
        put({6'h05, 1'b0, r3[19:0], 5'd5});
        put(enc_ri12(10'h00a, 5'd5, 5'd5, r4[11:0]));
        put(enc_3r(5'h00, 5'd6, 5'd4, 5'd5));
        put(enc_3r(5'h02, 5'd7, 5'd4, 5'd5));
        put(enc_3r(5'h04, 5'd8, 5'd4, 5'd5));
        put(enc_3r(5'h05, 5'd9, 5'd4, 5'd5));
        put(enc_3r(5'h08, 5'd10, 5'd4, 5'd5));
        put(enc_3r(5'h09, 5'd11, 5'd4, 5'd5));
        put(enc_3r(5'h0a, 5'd12, 5'd4, 5'd5));
        put(enc_3r(5'h0b, 5'd13, 5'd4, 5'd5));
        put(enc_shift(5'h01, 5'd14, 5'd4, 5'd7));
        put(enc_shift(5'h09, 5'd15, 5'd4, 5'd13));
        put(enc_shift(5'h11, 5'd16, 5'd5, 5'd21));
        put(enc_ri12(10'h00a, 5'd0, 5'd4, 12'h005));
        put(enc_3r(5'h00, 5'd17, 5'd0, 5'd5));
        put(32'hffff_ffff);
        put(enc_ri12(10'h00a, 5'd20, 5'd0, 12'h100));
        put(enc_ri12(10'h0a6, 5'd6, 5'd20, 12'h000));
        put(enc_ri12(10'h0a6, 5'd7, 5'd20, 12'h004));
        put(enc_ri12(10'h0a2, 5'd21, 5'd20, 12'h000));
        put(enc_ri12(10'h0a2, 5'd22, 5'd20, 12'h004));
        put(enc_ri12(10'h00a, 5'd23, 5'd0, 12'h005));
        put(enc_ri12(10'h00a, 5'd24, 5'd0, 12'h000));
        put(enc_3r(5'h00, 5'd24, 5'd24, 5'd4));
        put(enc_ri12(10'h0a6, 5'd24, 5'd20, 12'h008));
        put(enc_ri12(10'h00a, 5'd23, 5'd23, 12'hfff));
        put(enc_ri16(6'h17, 5'd0, 5'd23, 16'hfffd));
        put(enc_ri12(10'h0a2, 5'd25, 5'd20, 12'h008));
        put(enc_ri16(6'h16, 5'd24, 5'd25, 16'h0002));
        put(enc_ri12(10'h00a, 5'd26, 5'd0, 12'h001));
        put(enc_ri16(6'h16, 5'd0, 5'd20, 16'h0002));
        put(enc_i26(6'h15, 26'd3));
        put(enc_i26(6'h14, 26'd4));
        put(enc_ri12(10'h00a, 5'd27, 5'd0, 12'h007));
        put(enc_ri12(10'h00a, 5'd28, 5'd0, 12'h009));
        put(enc_ri16(6'h13, 5'd2, 5'd1, 16'h0000));
        put(enc_3r(5'h04, 5'd29, 5'd5, 5'd4));
        halt_pc = `CPU_PC_RESET + 32'(prog_len * 4);
        put(halt_word);
    endtask

    always @(negedge clk) begin
        // read data follows the address of the previous cycle.
        inst_sram_rdata = imem[imem_index(inst_addr_q)];
        data_sram_rdata = dmem[data_addr_q[9:2]];
        inst_addr_q = inst_sram_addr;
        data_addr_q = data_sram_addr;
    end

    // outputs are compared at the edge that ends their cycle.
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (debug_wb_rf_we != 4'h0) begin
                model_next(ev_kind, ev_pc, ev_num, ev_val, ev_addr);
                check_event(1, ev_kind);
                check_value("debug_wb_pc", debug_wb_pc, ev_pc);
                check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(ev_num));
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, ev_val);
            end
            if (data_sram_we) begin
                model_next(ev_kind, ev_pc, ev_num, ev_val, ev_addr);
                check_event(2, ev_kind);
                check_value("data_sram_addr", data_sram_addr, ev_addr);
                check_value("data_sram_wdata", data_sram_wdata, ev_val);
                dmem[data_sram_addr[9:2]] = data_sram_wdata;
            end
            if (inst_sram_addr == halt_pc)
                halt_count++;
            if (DUT.u_chk.fired) begin
                $display("a protocol assertion in mycpu_chk failed");
                stop_on_error();
            end
            if (cycle_count >= cycle_limit) begin
                $display("timeout: the program did not reach its final self-branch");
                stop_on_error();
            end
        end
    end

    initial begin
        reset = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        inst_addr_q = `CPU_PC_RESET;
        data_addr_q = 32'd0;
        cycle_count = 0;
        halt_count = 0;
        void'($urandom(32'h70e1545f));
        for (int i = 0; i < `CPU_IMEM_WORDS; i++) begin
            imem[i] = {6'h3f, 18'd0, i[7:0]};
        end
        for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
            dmem[i] = 32'hd0d0_0000 ^ (i * 32'h0101_0101);
            m_dmem[i] = dmem[i];
        end
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            m_regs[i] = 32'd0;
        end
        m_pc = `CPU_PC_RESET;
        build_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // the halt pc is held through the last exe and wb, then fetched twice.
        wait (halt_count >= 6);
        @(negedge clk);
        model_next(ev_kind, ev_pc, ev_num, ev_val, ev_addr);
        check_event(0, ev_kind);
        if (DUT.u_chk.fired == 1'b0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule
